// ==== common/tlb_pkg.sv ====
package tlb_pkg;

    // geometry
    localparam int tlb_num     = 16;
    localparam int tlb_log_num = 4;

    // field widths
    localparam int vppn_wd   = 19;
    localparam int ppn_wd    = 20;
    localparam int asid_wd   = 10;
    localparam int ps_wd     = 6;
    localparam int plv_wd    = 2;
    localparam int mat_wd    = 2;
    localparam int inv_op_wd = 5;

    // supported page sizes as log2 of the page size
    localparam logic [ps_wd-1:0] ps_4k = 6'd12;
    localparam logic [ps_wd-1:0] ps_4m = 6'd21;

    // vppn is va[31:13], so a 4 MB pair compares vppn[18:9] and picks odd on vppn[8]
    localparam int vppn_4m_lsb = ps_4m - ps_4k;

    // one page descriptor
    typedef struct packed {
        logic [ppn_wd-1:0] ppn;
        logic [plv_wd-1:0] plv;
        logic [mat_wd-1:0] mat;
        logic              d;
        logic              v;
    } tlb_page_t;

    // one entry with page0 even and page1 odd
    typedef struct packed {
        logic               e;
        logic [vppn_wd-1:0] vppn;
        logic [ps_wd-1:0]   ps;
        logic [asid_wd-1:0] asid;
        logic               g;
        tlb_page_t          page0;
        tlb_page_t          page1;
    } tlb_entry_t;

    // search answer
    typedef struct packed {
        logic                   found;
        logic [tlb_log_num-1:0] index;
        logic [ps_wd-1:0]       ps;
        tlb_page_t              page;
    } tlb_result_t;

    // invtlb opcodes
    typedef enum logic [inv_op_wd-1:0] {
        inv_all0      = 5'd0,
        inv_all1      = 5'd1,
        inv_global    = 5'd2,
        inv_nonglobal = 5'd3,
        inv_asid      = 5'd4,
        inv_asid_va   = 5'd5,
        inv_va        = 5'd6
    } invtlb_op_e;

    // whole entry store as seen by the search ports
    typedef tlb_entry_t tlb_entries_t [tlb_num];

    // vppn compare honouring the entry's page size
    function automatic logic vppn_match(
        input tlb_entry_t         ent,
        input logic [vppn_wd-1:0] vppn
    );
        logic full_eq;
        logic high_eq;

        full_eq = (ent.vppn == vppn);
        high_eq = (ent.vppn[vppn_wd-1:vppn_4m_lsb] == vppn[vppn_wd-1:vppn_4m_lsb]);
        if (ent.ps == ps_4m)
        begin
            return high_eq;
        end
        return full_eq;
    endfunction

endpackage

// ==== common/tlb_lookup_if.sv ====
`timescale 1ns/1ps

// one search port between the top level and a match port
interface tlb_lookup_if;

    import tlb_pkg::*;

    // request valid for the single cycle req is high
    logic               req;
    logic [vppn_wd-1:0] vppn;
    logic               va_bit12;
    logic [asid_wd-1:0] asid;

    // answer one cycle after req
    logic               resp_valid;
    tlb_result_t        result;

    modport requester
    (
        output req,
        output vppn,
        output va_bit12,
        output asid,
        input  resp_valid,
        input  result
    );

    modport responder
    (
        input  req,
        input  vppn,
        input  va_bit12,
        input  asid,
        output resp_valid,
        output result
    );

endinterface

// ==== tlb/tlb_entry_array.sv ====
`timescale 1ns/1ps

module tlb_entry_array
(
    input  logic                                clk,
    input  logic                                arst_n,
    // write by index
    input  logic                                wr_valid,
    input  logic [tlb_pkg::tlb_log_num-1:0]     wr_index,
    input  tlb_pkg::tlb_entry_t                 wr_entry,
    // fill at the round-robin index
    input  logic                                fill_valid,
    input  tlb_pkg::tlb_entry_t                 fill_entry,
    // invalidate
    input  logic                                inv_valid,
    input  tlb_pkg::invtlb_op_e                 inv_op,
    input  logic [tlb_pkg::asid_wd-1:0]         inv_asid,
    input  logic [tlb_pkg::vppn_wd-1:0]         inv_vppn,
    // read by index
    input  logic                                rd_valid,
    input  logic [tlb_pkg::tlb_log_num-1:0]     rd_index,
    output logic                                rd_resp_valid,
    output tlb_pkg::tlb_entry_t                 rd_entry,
    // full store to the search ports
    output tlb_pkg::tlb_entries_t               entries
);

    import tlb_pkg::*;

    // e bits held apart from the entry payload
    logic [tlb_num-1:0]     ent_e;
    tlb_entry_t             ent_q [tlb_num];
    logic [tlb_log_num-1:0] fill_idx;

    logic                   fill_go;
    logic                   inv_go;
    logic [tlb_num-1:0]     asid_eq;
    logic [tlb_num-1:0]     va_eq;
    logic [tlb_num-1:0]     inv_hit;

    // write beats fill, fill beats invalidate
    assign fill_go = fill_valid & ~wr_valid;
    assign inv_go  = inv_valid & ~wr_valid & ~fill_valid;

    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            entries[i]   = ent_q[i];
            entries[i].e = ent_e[i];
        end
    end

    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            asid_eq[i] = (ent_q[i].asid == inv_asid);
            va_eq[i]   = vppn_match(ent_q[i], inv_vppn);
        end
    end

    // which entries an invtlb op clears
    // the inv_asid port shadows the opcode of the same name
    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            case (inv_op)
                tlb_pkg::inv_all0,
                tlb_pkg::inv_all1:      inv_hit[i] = 1'b1;
                tlb_pkg::inv_global:    inv_hit[i] = ent_q[i].g;
                tlb_pkg::inv_nonglobal: inv_hit[i] = ~ent_q[i].g;
                tlb_pkg::inv_asid:      inv_hit[i] = ~ent_q[i].g & asid_eq[i];
                tlb_pkg::inv_asid_va:   inv_hit[i] = ~ent_q[i].g & asid_eq[i] & va_eq[i];
                tlb_pkg::inv_va:        inv_hit[i] = (ent_q[i].g | asid_eq[i]) & va_eq[i];
                default:                inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ent_e    <= '0;
            fill_idx <= '0;
        end
        else
        begin
            if (wr_valid)
            begin
                ent_e[wr_index] <= wr_entry.e;
            end
            else if (fill_go)
            begin
                ent_e[fill_idx] <= fill_entry.e;
                fill_idx        <= fill_idx + 1'b1;
            end
            else if (inv_go)
            begin
                ent_e <= ent_e & ~inv_hit;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            ent_q[wr_index] <= wr_entry;
        end
        else if (fill_go)
        begin
            ent_q[fill_idx] <= fill_entry;
        end
    end

    // read answer sees old contents on a same-edge write
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_resp_valid <= 1'b0;
        end
        else
        begin
            rd_resp_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            rd_entry <= entries[rd_index];
        end
    end

endmodule

// ==== tlb/tlb_match_port.sv ====
`timescale 1ns/1ps

module tlb_match_port
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  tlb_pkg::tlb_entries_t entries,
    tlb_lookup_if.responder       lk
);

    import tlb_pkg::*;

    logic [tlb_num-1:0]     hit;
    logic [tlb_log_num-1:0] hit_idx;
    logic                   found;
    tlb_entry_t             hit_ent;
    logic                   odd;
    tlb_result_t            result_d;

    // per-entry compare
    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            hit[i] = entries[i].e
                   & (entries[i].g | (entries[i].asid == lk.asid))
                   & vppn_match(entries[i], lk.vppn);
        end
    end

    // lowest index wins, so scan from the top down
    always_comb
    begin
        hit_idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--)
        begin
            if (hit[i])
            begin
                hit_idx = tlb_log_num'(i);
            end
        end
    end

    assign found   = |hit;
    assign hit_ent = entries[hit_idx];

    // odd page from va[12] for 4 KB and va[21] for 4 MB
    assign odd = (hit_ent.ps == ps_4m) ? lk.vppn[vppn_4m_lsb-1] : lk.va_bit12;

    always_comb
    begin
        result_d = '0;
        if (found)
        begin
            result_d.found = 1'b1;
            result_d.index = hit_idx;
            result_d.ps    = hit_ent.ps;
            result_d.page  = odd ? hit_ent.page1 : hit_ent.page0;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lk.resp_valid <= 1'b0;
        end
        else
        begin
            lk.resp_valid <= lk.req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lk.req)
        begin
            lk.result <= result_d;
        end
    end

endmodule

// ==== verilog/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top
(
    input  logic                              clk,
    input  logic                              arst_n,
    // write by index
    input  logic                              wr_valid,
    input  logic [tlb_pkg::tlb_log_num-1:0]   wr_index,
    input  tlb_pkg::tlb_entry_t               wr_entry,
    // fill
    input  logic                              fill_valid,
    input  tlb_pkg::tlb_entry_t               fill_entry,
    // invtlb
    input  logic                              inv_valid,
    input  tlb_pkg::invtlb_op_e               inv_op,
    input  logic [tlb_pkg::asid_wd-1:0]       inv_asid,
    input  logic [tlb_pkg::vppn_wd-1:0]       inv_vppn,
    // search port 0 for fetch
    input  logic                              s0_req,
    input  logic [tlb_pkg::vppn_wd-1:0]       s0_vppn,
    input  logic                              s0_va_bit12,
    input  logic [tlb_pkg::asid_wd-1:0]       s0_asid,
    output logic                              s0_resp_valid,
    output tlb_pkg::tlb_result_t              s0_result,
    // search port 1 for load/store and tlbsrch
    input  logic                              s1_req,
    input  logic [tlb_pkg::vppn_wd-1:0]       s1_vppn,
    input  logic                              s1_va_bit12,
    input  logic [tlb_pkg::asid_wd-1:0]       s1_asid,
    output logic                              s1_resp_valid,
    output tlb_pkg::tlb_result_t              s1_result,
    // read by index
    input  logic                              rd_valid,
    input  logic [tlb_pkg::tlb_log_num-1:0]   rd_index,
    output logic                              rd_resp_valid,
    output tlb_pkg::tlb_entry_t               rd_entry
);

    import tlb_pkg::*;

    tlb_entries_t entries;

    tlb_lookup_if lk0 ();
    tlb_lookup_if lk1 ();

    // port 0
    assign lk0.req       = s0_req;
    assign lk0.vppn      = s0_vppn;
    assign lk0.va_bit12  = s0_va_bit12;
    assign lk0.asid      = s0_asid;
    assign s0_resp_valid = lk0.resp_valid;
    assign s0_result     = lk0.result;

    // port 1
    assign lk1.req       = s1_req;
    assign lk1.vppn      = s1_vppn;
    assign lk1.va_bit12  = s1_va_bit12;
    assign lk1.asid      = s1_asid;
    assign s1_resp_valid = lk1.resp_valid;
    assign s1_result     = lk1.result;

    tlb_entry_array u_entry_array
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr_valid      (wr_valid),
        .wr_index      (wr_index),
        .wr_entry      (wr_entry),
        .fill_valid    (fill_valid),
        .fill_entry    (fill_entry),
        .inv_valid     (inv_valid),
        .inv_op        (inv_op),
        .inv_asid      (inv_asid),
        .inv_vppn      (inv_vppn),
        .rd_valid      (rd_valid),
        .rd_index      (rd_index),
        .rd_resp_valid (rd_resp_valid),
        .rd_entry      (rd_entry),
        .entries       (entries)
    );

    tlb_match_port u_match_fetch
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .entries (entries),
        .lk      (lk0.responder)
    );

    tlb_match_port u_match_data
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .entries (entries),
        .lk      (lk1.responder)
    );

endmodule

// ==== bench/tb_tlb_top.sv ====
`timescale 1ns/1ps

module tb_tlb_top;

    import tlb_pkg::*;

    logic                   clk;
    logic                   arst_n;
    logic                   wr_valid;
    logic [tlb_log_num-1:0] wr_index;
    tlb_entry_t             wr_entry;
    logic                   fill_valid;
    tlb_entry_t             fill_entry;
    logic                   inv_valid;
    invtlb_op_e             inv_op;
    logic [asid_wd-1:0]     inv_asid;
    logic [vppn_wd-1:0]     inv_vppn;
    logic                   s0_req;
    logic [vppn_wd-1:0]     s0_vppn;
    logic                   s0_va_bit12;
    logic [asid_wd-1:0]     s0_asid;
    logic                   s0_resp_valid;
    tlb_result_t            s0_result;
    logic                   s1_req;
    logic [vppn_wd-1:0]     s1_vppn;
    logic                   s1_va_bit12;
    logic [asid_wd-1:0]     s1_asid;
    logic                   s1_resp_valid;
    tlb_result_t            s1_result;
    logic                   rd_valid;
    logic [tlb_log_num-1:0] rd_index;
    logic                   rd_resp_valid;
    tlb_entry_t             rd_entry;

    int                     pass_cnt;
    int                     fail_cnt;
    int                     fd;
    int                     n;
    logic [8*256-1:0]       line;
    logic [8*16-1:0]        op;
    logic [8*16-1:0]        name;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8, f9;
    logic [31:0] f10, f11, f12, f13, f14, f15, f16, f17;

    tlb_top i_tlb_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // page attr field packs plv, mat, d and v
    function automatic tlb_entry_t entry_from_fields(
        input logic [31:0] e, vppn, ps, asid, g,
        input logic [31:0] ppn0, at0, ppn1, at1
    );
        tlb_entry_t ent;

        ent.e     = e[0];
        ent.vppn  = vppn[vppn_wd-1:0];
        ent.ps    = ps[ps_wd-1:0];
        ent.asid  = asid[asid_wd-1:0];
        ent.g     = g[0];
        ent.page0 = {ppn0[ppn_wd-1:0], at0[5:0]};
        ent.page1 = {ppn1[ppn_wd-1:0], at1[5:0]};
        return ent;
    endfunction

    function automatic tlb_result_t result_from_fields(
        input logic [31:0] found, idx, ps, ppn, at
    );
        tlb_result_t res;

        res.found = found[0];
        res.index = idx[tlb_log_num-1:0];
        res.ps    = ps[ps_wd-1:0];
        res.page  = {ppn[ppn_wd-1:0], at[5:0]};
        return res;
    endfunction

    task automatic check_result(input logic [8*16-1:0] tname, input tlb_result_t exp,
                                input tlb_result_t act);
        if (act === exp)
        begin
            pass_cnt++;
            $display("PASS %0s", tname);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL %0s expected %h actual %h", tname, exp, act);
        end
    endtask

    // an invalid entry only has to show e clear
    task automatic check_entry(input logic [8*16-1:0] tname, input tlb_entry_t exp,
                               input tlb_entry_t act);
        logic ok;

        ok = exp.e ? (act === exp) : (act.e === 1'b0);
        if (ok)
        begin
            pass_cnt++;
            $display("PASS %0s", tname);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL %0s expected %h actual %h", tname, exp, act);
        end
    endtask

    task automatic write_by_index(input logic [31:0] idx, input tlb_entry_t ent);
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_index <= idx[tlb_log_num-1:0];
        wr_entry <= ent;
        @(posedge clk);
        wr_valid <= 1'b0;
        $display("done %0s", name);
    endtask

    task automatic fill_next(input tlb_entry_t ent);
        @(posedge clk);
        fill_valid <= 1'b1;
        fill_entry <= ent;
        @(posedge clk);
        fill_valid <= 1'b0;
        $display("done %0s", name);
    endtask

    task automatic invalidate(input logic [31:0] code, asid, vppn);
        @(posedge clk);
        inv_valid <= 1'b1;
        inv_op    <= invtlb_op_e'(code[4:0]);
        inv_asid  <= asid[asid_wd-1:0];
        inv_vppn  <= vppn[vppn_wd-1:0];
        @(posedge clk);
        inv_valid <= 1'b0;
        $display("done %0s", name);
    endtask

    task automatic read_by_index(input logic [31:0] idx, input tlb_entry_t exp);
        int waits;
        logic got;

        @(posedge clk);
        rd_valid <= 1'b1;
        rd_index <= idx[tlb_log_num-1:0];
        @(posedge clk);
        rd_valid <= 1'b0;
        got   = 1'b0;
        waits = 0;
        while (!got && waits < 4)
        begin
            @(negedge clk);
            waits++;
            if (rd_resp_valid)
            begin
                got = 1'b1;
                check_entry(name, exp, rd_entry);
            end
        end
        if (!got)
        begin
            fail_cnt++;
            $display("timeout: read %0s got no response within 4 cycles", name);
        end
    endtask

    // search on one or both ports and optionally write on the same edge
    task automatic search_ports(input logic use0, input logic [31:0] v0, b0, a0,
                                input tlb_result_t e0,
                                input logic use1, input logic [31:0] v1, b1, a1,
                                input tlb_result_t e1,
                                input logic wr_too, input logic [31:0] widx,
                                input tlb_entry_t went);
        int waits;
        logic got0;
        logic got1;

        @(posedge clk);
        s0_req      <= use0;
        s0_vppn     <= v0[vppn_wd-1:0];
        s0_va_bit12 <= b0[0];
        s0_asid     <= a0[asid_wd-1:0];
        s1_req      <= use1;
        s1_vppn     <= v1[vppn_wd-1:0];
        s1_va_bit12 <= b1[0];
        s1_asid     <= a1[asid_wd-1:0];
        wr_valid    <= wr_too;
        wr_index    <= widx[tlb_log_num-1:0];
        wr_entry    <= went;
        @(posedge clk);
        s0_req   <= 1'b0;
        s1_req   <= 1'b0;
        wr_valid <= 1'b0;
        got0  = !use0;
        got1  = !use1;
        waits = 0;
        while (!(got0 && got1) && waits < 4)
        begin
            @(negedge clk);
            waits++;
            if (!got0 && s0_resp_valid)
            begin
                got0 = 1'b1;
                check_result(name, e0, s0_result);
            end
            if (!got1 && s1_resp_valid)
            begin
                got1 = 1'b1;
                check_result(name, e1, s1_result);
            end
        end
        if (!(got0 && got1))
        begin
            fail_cnt++;
            $display("timeout: search %0s got no response within 4 cycles", name);
        end
    endtask

    task automatic run_line();
        tlb_result_t none;

        none = '0;
        if (op == "wr" || op == "rd")
        begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", op, name,
                        f0, f1, f2, f3, f4, f5, f6, f7, f8, f9);
        end
        else if (op == "fill")
        begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", op, name,
                        f1, f2, f3, f4, f5, f6, f7, f8, f9) + 1;
        end
        else if (op == "inv")
        begin
            n = $sscanf(line, "%s %s %h %h %h", op, name, f0, f1, f2) + 7;
        end
        else if (op == "look0" || op == "look1")
        begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", op, name,
                        f0, f1, f2, f3, f4, f5, f6, f7) + 2;
        end
        else if (op == "look2")
        begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, name, f0, f1, f2, f3, f4, f5, f6, f7,
                        f8, f9, f10, f11, f12, f13, f14, f15) - 6;
        end
        else if (op == "wrlook")
        begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, name, f0, f1, f2, f3, f4, f5, f6, f7, f8, f9,
                        f10, f11, f12, f13, f14, f15, f16, f17) - 8;
        end
        else
        begin
            n = 0;
        end
        if (n != 12)
        begin
            fail_cnt++;
            $display("malformed line in the test file, operation %0s", op);
        end
        else if (op == "wr")
            write_by_index(f0, entry_from_fields(f1, f2, f3, f4, f5, f6, f7, f8, f9));
        else if (op == "rd")
            read_by_index(f0, entry_from_fields(f1, f2, f3, f4, f5, f6, f7, f8, f9));
        else if (op == "fill")
            fill_next(entry_from_fields(f1, f2, f3, f4, f5, f6, f7, f8, f9));
        else if (op == "inv")
            invalidate(f0, f1, f2);
        else if (op == "look0")
            search_ports(1'b1, f0, f1, f2, result_from_fields(f3, f4, f5, f6, f7),
                         1'b0, 0, 0, 0, none, 1'b0, 0, '0);
        else if (op == "look1")
            search_ports(1'b0, 0, 0, 0, none,
                         1'b1, f0, f1, f2, result_from_fields(f3, f4, f5, f6, f7),
                         1'b0, 0, '0);
        else if (op == "look2")
            search_ports(1'b1, f0, f1, f2, result_from_fields(f3, f4, f5, f6, f7),
                         1'b1, f8, f9, f10, result_from_fields(f11, f12, f13, f14, f15),
                         1'b0, 0, '0);
        else
            search_ports(1'b0, 0, 0, 0, none,
                         1'b1, f10, f11, f12, result_from_fields(f13, f14, f15, f16, f17),
                         1'b1, f0, entry_from_fields(f1, f2, f3, f4, f5, f6, f7, f8, f9));
    endtask

    initial
    begin
        pass_cnt    = 0;
        fail_cnt    = 0;
        arst_n      = 1'b0;
        wr_valid    = 1'b0;
        wr_index    = '0;
        wr_entry    = '0;
        fill_valid  = 1'b0;
        fill_entry  = '0;
        inv_valid   = 1'b0;
        inv_op      = inv_all0;
        inv_asid    = '0;
        inv_vppn    = '0;
        s0_req      = 1'b0;
        s0_vppn     = '0;
        s0_va_bit12 = 1'b0;
        s0_asid     = '0;
        s1_req      = 1'b0;
        s1_vppn     = '0;
        s1_va_bit12 = 1'b0;
        s1_asid     = '0;
        rd_valid    = 1'b0;
        rd_index    = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("bench/tlb_tests.txt", "r");
        if (fd == 0)
        begin
            fail_cnt++;
            $display("could not open bench/tlb_tests.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = '0;
                op   = '0;
                n    = $fgets(line, fd);
                // blank lines and lines whose first token is # are skipped
                if (n > 0 && $sscanf(line, "%s", op) == 1 && op != "#")
                begin
                    run_line();
                end
            end
            $fclose(fd);
        end

        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/tlb_tests.txt ====
# op name fields, all hex; entry = e vppn ps asid g ppn0 attr0 ppn1 attr1, attr = {plv,mat,d,v}
# result = found idx ps ppn attr; look ports take vppn va_bit12 asid then the result
look2 rst_miss 00010 0 001 0 0 00 00000 00 00020 1 001 0 0 00 00000 00
rd rst_rd5 5 0 00000 00 000 0 00000 00 00000 00
# 4 KB write, read back, page select and asid
wr w_e3 3 1 00100 0c 005 0 11000 1f 11001 0e
wr w_e4 4 1 00200 0c 006 1 22000 13 22001 03
rd rd_e3 3 1 00100 0c 005 0 11000 1f 11001 0e
rd rd_e4 4 1 00200 0c 006 1 22000 13 22001 03
look0 pg_even 00100 0 005 1 3 0c 11000 1f
look1 pg_odd 00100 1 005 1 3 0c 11001 0e
look0 asid_miss 00100 0 007 0 0 00 00000 00
look1 glob_hit 00200 1 3ff 1 4 0c 22001 03
# 4 MB entry at 7, 4 KB overlap at 9
wr w_m7 7 1 40000 15 005 0 33000 04 33001 05
look0 m_even 400ff 1 005 1 7 15 33000 04
look1 m_odd 40100 0 005 1 7 15 33001 05
wr w_k9 9 1 40100 0c 005 0 44000 01 44001 02
look1 m_low 40100 0 005 1 7 15 33001 05
# fills land at 0, 1, 2
fill f0 1 01000 0c 00a 0 50000 00 50001 00
fill f1 1 01001 0c 00a 0 51000 00 51001 00
fill f2 1 01002 0c 00a 0 52000 00 52001 00
rd rd_f0 0 1 01000 0c 00a 0 50000 00 50001 00
rd rd_f1 1 1 01001 0c 00a 0 51000 00 51001 00
rd rd_f2 2 1 01002 0c 00a 0 52000 00 52001 00
wr w_over1 1 1 01003 0c 00b 1 53000 07 53001 08
rd rd_over1 1 1 01003 0c 00b 1 53000 07 53001 08
# invalidate
inv i_asid_va 5 00a 01002
rd rd_i5_2 2 0 00000 00 000 0 00000 00 00000 00
rd rd_i5_0 0 1 01000 0c 00a 0 50000 00 50001 00
inv i_va 6 005 40123
look1 lk_i6 40100 0 005 1 9 0c 44000 01
inv i_asid 4 005 00000
look0 lk_i4 00100 0 005 0 0 00 00000 00
rd rd_i4_9 9 0 00000 00 000 0 00000 00 00000 00
look1 lk_i4_g 00200 0 3ff 1 4 0c 22000 13
inv i_global 2 000 00000
rd rd_i2_1 1 0 00000 00 000 0 00000 00 00000 00
look1 lk_i2 00200 0 3ff 0 0 00 00000 00
rd rd_i2_0 0 1 01000 0c 00a 0 50000 00 50001 00
inv i_nonglob 3 000 00000
rd rd_i3_0 0 0 00000 00 000 0 00000 00 00000 00
wr w_a5 5 1 00500 0c 001 1 55000 01 55001 01
wr w_a6 6 1 00600 0c 002 0 56000 01 56001 01
inv i_all0 0 000 00000
rd rd_i0_5 5 0 00000 00 000 0 00000 00 00000 00
rd rd_i0_6 6 0 00000 00 000 0 00000 00 00000 00
wr w_b5 5 1 00500 0c 001 1 55000 01 55001 01
inv i_all1 1 000 00000
look0 lk_i1 00500 0 001 0 0 00 00000 00
# parallel ports and same-edge rule
wr w_p10 a 1 06000 0c 010 0 60000 01 60001 02
wr w_p11 b 1 07000 0c 011 0 70000 03 70001 04
look2 par 06000 1 010 1 a 0c 60001 02 07000 0 011 1 b 0c 70000 03
wrlook same_edge b 1 07000 0c 011 0 7a000 05 7a001 06 07000 0 011 1 b 0c 70000 03
look1 next_edge 07000 0 011 1 b 0c 7a000 05

// ==== tlb.f ====
common/tlb_pkg.sv
common/tlb_lookup_if.sv
tlb/tlb_entry_array.sv
tlb/tlb_match_port.sv
verilog/tlb_top.sv
bench/tb_tlb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_tlb_top
FLIST     ?= tlb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
